/* Makefile */
# Verilator build and run of the FPU testbench

VERILATOR ?= verilator
TOP       ?= fpu_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "test did not pass"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
+incdir+verilog
+incdir+verification
verilog/fp_format_pkg.sv
verilog/fpu_pipe_pkg.sv
verilog/lead_norm.sv
verilog/fp_unpack_stage.sv
verilog/fp_exec_stage.sv
verilog/fp_norm_stage.sv
verilog/fpu_top.sv
verification/fpu_tb.sv

/* verification/fpu_cases.svh */
// each row gives the name, op, operand A, operand B and expected result as hex words
// rows are applied back to back at one per clock

task automatic load_table;
    // exactly representable add and sub
    add_row("add_1p5_2p25",    fpu_pipe_pkg::FPU_ADD, 32'h3FC0_0000, 32'h4010_0000, 32'h4070_0000);
    add_row("sub_3p0_5p5",     fpu_pipe_pkg::FPU_SUB, 32'h4040_0000, 32'h40B0_0000, 32'hC020_0000);
    add_row("sub_x_x",         fpu_pipe_pkg::FPU_SUB, 32'h40B0_0000, 32'h40B0_0000, 32'h0000_0000);
    add_row("add_m6_1",        fpu_pipe_pkg::FPU_ADD, 32'hC0C0_0000, 32'h3F80_0000, 32'hC0A0_0000);
    add_row("sub_1_0p75",      fpu_pipe_pkg::FPU_SUB, 32'h3F80_0000, 32'h3F40_0000, 32'h3E80_0000);

    // multiply without and with a product carry
    add_row("mul_1p5_m2",      fpu_pipe_pkg::FPU_MUL, 32'h3FC0_0000, 32'hC000_0000, 32'hC040_0000);
    add_row("mul_0p75_0p75",   fpu_pipe_pkg::FPU_MUL, 32'h3F40_0000, 32'h3F40_0000, 32'h3F10_0000);

    // =================================================================
    // special operands
    // =================================================================
    add_row("nan_a_add",       fpu_pipe_pkg::FPU_ADD, 32'h7FC1_2345, 32'h3F80_0000, 32'h7FC1_2345);
    add_row("nan_b_mul",       fpu_pipe_pkg::FPU_MUL, 32'h3F80_0000, 32'h7F80_0001, 32'h7F80_0001);
    add_row("nan_both_a_wins", fpu_pipe_pkg::FPU_ADD, 32'hFFC0_0001, 32'h7FC0_0002, 32'hFFC0_0001);
    add_row("add_zero_b",      fpu_pipe_pkg::FPU_ADD, 32'h0000_0000, 32'h4020_0000, 32'h4020_0000);
    add_row("sub_b_zero",      fpu_pipe_pkg::FPU_SUB, 32'h4020_0000, 32'h0000_0000, 32'h4020_0000);
    add_row("sub_zero_b",      fpu_pipe_pkg::FPU_SUB, 32'h0000_0000, 32'h4020_0000, 32'hC020_0000);
    add_row("sub_zero_zero",   fpu_pipe_pkg::FPU_SUB, 32'h0000_0000, 32'h0000_0000, 32'h8000_0000);
    add_row("mul_zero_neg",    fpu_pipe_pkg::FPU_MUL, 32'h0000_0000, 32'hC040_0000, 32'h8000_0000);
    // denormal input is flushed to zero
    add_row("add_denorm",      fpu_pipe_pkg::FPU_ADD, 32'h0000_0001, 32'h3F80_0000, 32'h3F80_0000);
    add_row("add_inf_opp",     fpu_pipe_pkg::FPU_ADD, 32'h7F80_0000, 32'hFF80_0000, 32'h7FC0_0000);
    add_row("sub_inf_inf",     fpu_pipe_pkg::FPU_SUB, 32'h7F80_0000, 32'h7F80_0000, 32'h7FC0_0000);
    add_row("add_inf_one",     fpu_pipe_pkg::FPU_ADD, 32'h7F80_0000, 32'h3F80_0000, 32'h7F80_0000);
    add_row("mul_zero_inf",    fpu_pipe_pkg::FPU_MUL, 32'h0000_0000, 32'h7F80_0000, 32'h7FC0_0000);
    add_row("mul_ninf_2",      fpu_pipe_pkg::FPU_MUL, 32'hFF80_0000, 32'h4000_0000, 32'hFF80_0000);

    // =================================================================
    // exponent range
    // =================================================================
    add_row("mul_ovf_pos",     fpu_pipe_pkg::FPU_MUL, 32'h7180_0000, 32'h7180_0000, 32'h7F80_0000);
    add_row("mul_ovf_neg",     fpu_pipe_pkg::FPU_MUL, 32'hF180_0000, 32'h7180_0000, 32'hFF80_0000);
    add_row("add_ovf_carry",   fpu_pipe_pkg::FPU_ADD, 32'h7F00_0000, 32'h7F00_0000, 32'h7F80_0000);
    add_row("mul_unf_pos",     fpu_pipe_pkg::FPU_MUL, 32'h0D80_0000, 32'h0D80_0000, 32'h0000_0000);
    add_row("mul_unf_neg",     fpu_pipe_pkg::FPU_MUL, 32'h8D80_0000, 32'h0D80_0000, 32'h8000_0000);
endtask

/* verification/fpu_tb.sv */
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;

    logic                   clk = 1'b0;
    logic                   i_arst_n;
    logic                   i_valid;
    fpu_pipe_pkg::fpu_op_t  i_op;
    fp_format_pkg::fp32_t   i_a;
    fp_format_pkg::fp32_t   i_b;
    logic                   o_valid;
    fp_format_pkg::fp32_t   o_result;

    // table rows
    string                  row_name[$];
    fpu_pipe_pkg::fpu_op_t  row_op[$];
    fp_format_pkg::fp32_t   row_a[$];
    fp_format_pkg::fp32_t   row_b[$];
    fp_format_pkg::fp32_t   row_exp[$];

    // items in flight with the oldest first
    string                  name_q[$];
    fp_format_pkg::fp32_t   exp_q[$];
    int                     due_q[$];
    int                     cycle = 0;

    fpu_top dut (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .i_op     (i_op),
        .i_a      (i_a),
        .i_b      (i_b),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

    task automatic add_row(input string name, input fpu_pipe_pkg::fpu_op_t op,
                           input fp_format_pkg::fp32_t a, input fp_format_pkg::fp32_t b,
                           input fp_format_pkg::fp32_t expected);
        row_name.push_back(name);
        row_op.push_back(op);
        row_a.push_back(a);
        row_b.push_back(b);
        row_exp.push_back(expected);
    endtask

    `include "fpu_cases.svh"

    // ======================================================================
    // checks
    // ======================================================================
    task automatic abort_run;
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input fp_format_pkg::fp32_t expected,
                                input fp_format_pkg::fp32_t actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_valid(input logic expected, input logic actual);
        if (actual !== expected) begin
            if (actual === 1'b1) begin
                $display("o_valid went high at cycle %0d with no item due", cycle);
            end else begin
                $display("o_valid stayed low at cycle %0d for a pending item", cycle);
            end
            abort_run();
        end
    endtask

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // an input seen here is sampled at the next rising edge and is due
    // FPU_LATENCY falling edges later
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (i_valid && i_arst_n) begin
            due_q.push_back(cycle + `FPU_LATENCY);
        end
        check_valid((due_q.size() != 0) && (due_q[0] == cycle), o_valid);
        if (o_valid) begin
            void'(due_q.pop_front());
            check_result(name_q.pop_front(), exp_q.pop_front(), o_result);
        end
    end

    initial begin
        @(posedge i_arst_n);
        #((row_exp.size() + `FPU_LATENCY + 10) * CLK_PERIOD);
        $display("timeout: results still missing after the whole table was applied");
        abort_run();
    end

    // ======================================================================
    // stimulus
    // ======================================================================
    initial begin
        i_arst_n = 1'b0;
        i_valid  = 1'b0;
        i_op     = fpu_pipe_pkg::FPU_ADD;
        i_a      = '0;
        i_b      = '0;
        load_table();

        @(negedge clk);
        check_result("after_reset", '0, o_result);
        repeat (RESET_CYCLES) @(posedge clk);
        i_arst_n <= 1'b1;

        for (int i = 0; i < row_exp.size(); i++) begin
            @(posedge clk);
            i_valid <= 1'b1;
            i_op    <= row_op[i];
            i_a     <= row_a[i];
            i_b     <= row_b[i];
            name_q.push_back(row_name[i]);
            exp_q.push_back(row_exp[i]);
        end
        @(posedge clk);
        i_valid <= 1'b0;

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // a few idle cycles catch a stray o_valid
        repeat (3) @(negedge clk);
        @(posedge clk);

        $display("sim passed");
        $finish;
    end

endmodule

/* verilog/fp_exec_stage.sv */
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fp_exec_stage (
    input  logic                          clk,
    input  logic                          i_arst_n,
    input  fpu_pipe_pkg::unpack_to_exec_t i_stage,
    output fpu_pipe_pkg::exec_to_norm_t   o_stage
);

    fp_format_pkg::fp_unpacked_t a;
    fp_format_pkg::fp_unpacked_t b;
    fp_format_pkg::fp_unpacked_t big;
    fp_format_pkg::fp_unpacked_t smaller;
    logic                        a_big;
    logic                        is_mul;
    logic [`FP_EXP_W-1:0]        diff;
    logic [`FP_MANT_W-1:0]       shifted;
    fpu_pipe_pkg::sum_mant_t     sum;
    fpu_pipe_pkg::prod_mant_t    prod;
    fpu_pipe_pkg::wexp_t         mul_exp;
    fpu_pipe_pkg::exec_to_norm_t next_stage;

    assign a      = i_stage.a;
    assign b      = i_stage.b;
    assign is_mul = (i_stage.op == fpu_pipe_pkg::FPU_MUL);

    // ======================================================================
    // add path
    // ======================================================================
    // the larger magnitude sets the exponent and the sign
    assign a_big   = {a.exp, a.mant} >= {b.exp, b.mant};
    assign big     = a_big ? a : b;
    assign smaller = a_big ? b : a;
    assign diff    = big.exp - smaller.exp;

    // bits shifted out are dropped so the result is truncated
    assign shifted = smaller.mant >> diff;

    always_comb begin
        if (big.sign == smaller.sign) begin
            sum = {1'b0, big.mant} + {1'b0, shifted};
        end else begin
            sum = {1'b0, big.mant} - {1'b0, shifted};
        end
    end

    // ======================================================================
    // multiply path
    // ======================================================================
    assign prod    = fpu_pipe_pkg::prod_mant_t'(a.mant)
                   * fpu_pipe_pkg::prod_mant_t'(b.mant);
    assign mul_exp = fpu_pipe_pkg::wexp_t'({2'b00, a.exp})
                   + fpu_pipe_pkg::wexp_t'({2'b00, b.exp})
                   - fpu_pipe_pkg::wexp_t'(`FP_BIAS);

    always_comb begin
        next_stage.valid       = i_stage.valid;
        next_stage.op          = i_stage.op;
        next_stage.sign        = is_mul ? (a.sign ^ b.sign) : big.sign;
        next_stage.exp         = is_mul ? mul_exp : fpu_pipe_pkg::wexp_t'({2'b00, big.exp});
        next_stage.sum         = sum;
        next_stage.prod        = prod;
        next_stage.special     = i_stage.special;
        next_stage.special_res = i_stage.special_res;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_stage <= '0;
        end else begin
            o_stage <= next_stage;
        end
    end

endmodule

/* verilog/fp_format_pkg.sv */
`include "fpu_consts.svh"

package fp_format_pkg;

    // ======================================================================
    // stored word
    // ======================================================================
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fp32_t;

    // ======================================================================
    // operand class after screening
    // ======================================================================
    // denormals are flushed, so exponent zero always means zero
    typedef enum logic [1:0] {
        CLS_ZERO   = 2'd0,
        CLS_NORMAL = 2'd1,
        CLS_INF    = 2'd2,
        CLS_NAN    = 2'd3
    } fp_class_t;

    // ======================================================================
    // unpacked operand
    // ======================================================================
    // mantissa carries the hidden bit in its top position
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_MANT_W-1:0] mant;
        fp_class_t             cls;
    } fp_unpacked_t;

endpackage

/* verilog/fp_norm_stage.sv */
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fp_norm_stage (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  fpu_pipe_pkg::exec_to_norm_t i_stage,
    output logic                        o_valid,
    output fp_format_pkg::fp32_t        o_result
);

    fpu_pipe_pkg::wexp_t      sum_exp;
    fpu_pipe_pkg::sum_mant_t  sum_mant;
    fpu_pipe_pkg::wexp_t      prod_exp;
    fpu_pipe_pkg::prod_mant_t prod_mant;
    fpu_pipe_pkg::wexp_t      n_exp;
    logic [`FP_FRAC_W-1:0]    n_frac;
    logic                     is_mul;
    logic                     mant_zero;
    logic                     out_nan;
    fp_format_pkg::fp32_t     result;

    lead_norm #(
        .mant_t (fpu_pipe_pkg::sum_mant_t)
    ) u_sum_norm (
        .i_exp  (i_stage.exp),
        .i_mant (i_stage.sum),
        .o_exp  (sum_exp),
        .o_mant (sum_mant)
    );

    lead_norm #(
        .mant_t (fpu_pipe_pkg::prod_mant_t)
    ) u_prod_norm (
        .i_exp  (i_stage.exp),
        .i_mant (i_stage.prod),
        .o_exp  (prod_exp),
        .o_mant (prod_mant)
    );

    assign is_mul    = (i_stage.op == fpu_pipe_pkg::FPU_MUL);
    assign mant_zero = is_mul ? (i_stage.prod == '0) : (i_stage.sum == '0);
    assign n_exp     = is_mul ? prod_exp : sum_exp;
    // fraction sits just below the hidden bit in each width
    assign n_frac    = is_mul ? prod_mant[2*`FP_FRAC_W-1:`FP_FRAC_W]
                              : sum_mant[`FP_FRAC_W-1:0];

    always_comb begin
        result = '0;
        if (i_stage.special) begin
            result = i_stage.special_res;
        end else if (mant_zero) begin
            // exact cancellation gives +0
            result = '0;
        end else if (n_exp < fpu_pipe_pkg::wexp_t'(1)) begin
            result.sign = i_stage.sign;
        end else if (n_exp >= fpu_pipe_pkg::wexp_t'(`FP_EXP_MAX)) begin
            result.sign = i_stage.sign;
            result.exp  = `FP_EXP_W'(`FP_EXP_MAX);
        end else begin
            result.sign = i_stage.sign;
            result.exp  = n_exp[`FP_EXP_W-1:0];
            result.frac = n_frac;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid  <= 1'b0;
            o_result <= '0;
        end else begin
            o_valid  <= i_stage.valid;
            o_result <= result;
        end
    end

    assign out_nan = (o_result.exp == `FP_EXP_MAX) && (o_result.frac != '0);

    // the computed path saturates to infinity, so a NaN can only come from screening
    a_nan_only_special: assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_valid && out_nan) |-> $past(i_stage.special));

endmodule

/* verilog/fp_unpack_stage.sv */
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fp_unpack_stage (
    input  logic                          clk,
    input  logic                          i_arst_n,
    input  logic                          i_valid,
    input  fpu_pipe_pkg::fpu_op_t         i_op,
    input  fp_format_pkg::fp32_t          i_a,
    input  fp_format_pkg::fp32_t          i_b,
    output fpu_pipe_pkg::unpack_to_exec_t o_stage
);

    fp_format_pkg::fp_unpacked_t   a_u;
    fp_format_pkg::fp_unpacked_t   b_u;
    fpu_pipe_pkg::unpack_to_exec_t next_stage;
    logic                          is_sub;
    logic                          is_mul;
    logic                          a_zero;
    logic                          b_zero;
    logic                          a_inf;
    logic                          b_inf;
    logic                          sign_x;

    function automatic fp_format_pkg::fp_unpacked_t unpack(input fp_format_pkg::fp32_t f);
        fp_format_pkg::fp_unpacked_t u;
        u.sign = f.sign;
        u.exp  = f.exp;
        u.mant = {1'b1, f.frac};
        u.cls  = fp_format_pkg::CLS_NORMAL;
        if (f.exp == '0) begin
            u.exp  = '0;
            u.mant = '0;
            u.cls  = fp_format_pkg::CLS_ZERO;
        end else if (f.exp == `FP_EXP_MAX) begin
            u.cls = (f.frac == '0) ? fp_format_pkg::CLS_INF : fp_format_pkg::CLS_NAN;
        end
        return u;
    endfunction

    function automatic fp_format_pkg::fp32_t repack(input fp_format_pkg::fp_unpacked_t u);
        fp_format_pkg::fp32_t f;
        f.sign = u.sign;
        f.exp  = u.exp;
        f.frac = u.mant[`FP_FRAC_W-1:0];
        return f;
    endfunction

    assign is_sub = (i_op == fpu_pipe_pkg::FPU_SUB);
    assign is_mul = (i_op == fpu_pipe_pkg::FPU_MUL);

    always_comb begin
        a_u = unpack(i_a);
        b_u = unpack(i_b);
        // subtraction becomes addition of the negated B
        if (is_sub) begin
            b_u.sign = ~b_u.sign;
        end
    end

    assign a_zero = (a_u.cls == fp_format_pkg::CLS_ZERO);
    assign b_zero = (b_u.cls == fp_format_pkg::CLS_ZERO);
    assign a_inf  = (a_u.cls == fp_format_pkg::CLS_INF);
    assign b_inf  = (b_u.cls == fp_format_pkg::CLS_INF);
    assign sign_x = a_u.sign ^ b_u.sign;

    always_comb begin
        next_stage.valid       = i_valid;
        next_stage.op          = is_sub ? fpu_pipe_pkg::FPU_ADD : i_op;
        next_stage.a           = a_u;
        next_stage.b           = b_u;
        next_stage.special     = 1'b1;
        next_stage.special_res = '0;
        if (i_op == fpu_pipe_pkg::FPU_RSVD) begin
            next_stage.special_res = `FP_QNAN;
        end else if (a_u.cls == fp_format_pkg::CLS_NAN) begin
            next_stage.special_res = i_a;
        end else if (b_u.cls == fp_format_pkg::CLS_NAN) begin
            next_stage.special_res = i_b;
        end else if (is_mul) begin
            if ((a_zero && b_inf) || (a_inf && b_zero)) begin
                next_stage.special_res = `FP_QNAN;
            end else if (a_zero || b_zero) begin
                next_stage.special_res.sign = sign_x;
            end else if (a_inf || b_inf) begin
                next_stage.special_res.sign = sign_x;
                next_stage.special_res.exp  = `FP_EXP_W'(`FP_EXP_MAX);
            end else begin
                next_stage.special = 1'b0;
            end
        end else begin
            if (a_zero) begin
                next_stage.special_res = repack(b_u);
            end else if (b_zero) begin
                next_stage.special_res = repack(a_u);
            end else if (a_inf && b_inf && sign_x) begin
                next_stage.special_res = `FP_QNAN;
            end else if (a_inf) begin
                next_stage.special_res = repack(a_u);
            end else if (b_inf) begin
                next_stage.special_res = repack(b_u);
            end else begin
                next_stage.special = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_stage <= '0;
        end else begin
            o_stage <= next_stage;
        end
    end

    // the reserved opcode must never reach the pipeline
    a_no_reserved_op: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_valid |-> (i_op != fpu_pipe_pkg::FPU_RSVD));

endmodule

/* verilog/fpu_consts.svh */
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// ======================================================================
// IEEE single format
// ======================================================================
`define FP_EXP_W 8
`define FP_FRAC_W 23

// fraction plus the hidden bit
`define FP_MANT_W 24

`define FP_BIAS 127
`define FP_EXP_MAX 255

// quiet NaN returned for invalid operations
`define FP_QNAN 32'h7FC0_0000

// ======================================================================
// pipeline
// ======================================================================
`define FPU_LATENCY 3

`endif

/* verilog/fpu_pipe_pkg.sv */
`include "fpu_consts.svh"

package fpu_pipe_pkg;

    // opcode 2 is reserved and never issued
    typedef enum logic [1:0] {
        FPU_ADD  = 2'd0,
        FPU_SUB  = 2'd1,
        FPU_RSVD = 2'd2,
        FPU_MUL  = 2'd3
    } fpu_op_t;

    // two extra bits let the exponent show underflow and overflow
    typedef logic signed [`FP_EXP_W+1:0] wexp_t;

    // sum keeps a carry bit above the hidden bit
    typedef logic [`FP_MANT_W:0] sum_mant_t;
    typedef logic [2*`FP_MANT_W-1:0] prod_mant_t;

    // ======================================================================
    // stage 1 to stage 2
    // ======================================================================
    typedef struct packed {
        logic                        valid;
        fpu_op_t                     op;
        fp_format_pkg::fp_unpacked_t a;
        fp_format_pkg::fp_unpacked_t b;
        logic                        special;
        fp_format_pkg::fp32_t        special_res;
    } unpack_to_exec_t;

    // ======================================================================
    // stage 2 to stage 3
    // ======================================================================
    typedef struct packed {
        logic                 valid;
        fpu_op_t              op;
        logic                 sign;
        wexp_t                exp;
        sum_mant_t            sum;
        prod_mant_t           prod;
        logic                 special;
        fp_format_pkg::fp32_t special_res;
    } exec_to_norm_t;

endpackage

/* verilog/fpu_top.sv */
`timescale 1ns/1ps

module fpu_top (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_valid,
    input  fpu_pipe_pkg::fpu_op_t i_op,
    input  fp_format_pkg::fp32_t  i_a,
    input  fp_format_pkg::fp32_t  i_b,
    output logic                  o_valid,
    output fp_format_pkg::fp32_t  o_result
);

    fpu_pipe_pkg::unpack_to_exec_t unpack_to_exec;
    fpu_pipe_pkg::exec_to_norm_t   exec_to_norm;

    fp_unpack_stage u_unpack (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .i_op     (i_op),
        .i_a      (i_a),
        .i_b      (i_b),
        .o_stage  (unpack_to_exec)
    );

    fp_exec_stage u_exec (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_stage  (unpack_to_exec),
        .o_stage  (exec_to_norm)
    );

    fp_norm_stage u_norm (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_stage  (exec_to_norm),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

endmodule

/* verilog/lead_norm.sv */
`timescale 1ns/1ps
`include "fpu_consts.svh"

// the top bit of mant_t is the carry, the one below it the hidden bit
module lead_norm #(
    parameter type mant_t = logic [`FP_MANT_W:0]
) (
    input  fpu_pipe_pkg::wexp_t i_exp,
    input  mant_t               i_mant,
    output fpu_pipe_pkg::wexp_t o_exp,
    output mant_t               o_mant
);

    localparam int W = $bits(mant_t);

    fpu_pipe_pkg::wexp_t shift;

    // distance from the leading one to the hidden bit position
    always_comb begin
        shift = fpu_pipe_pkg::wexp_t'(W - 1);
        for (int i = 0; i < W - 1; i++) begin
            if (i_mant[i]) begin
                shift = fpu_pipe_pkg::wexp_t'(W - 2 - i);
            end
        end
    end

    always_comb begin
        if (i_mant[W-1]) begin
            o_mant = i_mant >> 1;
            o_exp  = i_exp + fpu_pipe_pkg::wexp_t'(1);
        end else begin
            o_mant = i_mant << shift;
            o_exp  = i_exp - shift;
        end
    end

endmodule
